//--- compile.f
hw/tlp_pkg.sv
hw/endpoint_arbiter.sv
hw/rd_request_engine.sv
hw/wr_request_engine.sv
hw/interrupt_ctrl.sv
hw/endpoint_tx_port.sv
hw/dma_tx_top.sv
verification/dma_tx_assert.sv
verification/tb_dma_tx.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_dma_tx -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Regression passed" &&
echo "simulation ok" ||
{ echo "simulation did not pass"; exit 1; }

//--- verification/tb_dma_tx.sv
////////////////////////////////////////////////////////////////////////////
// testbench for dma_tx_top, stimulus table applied in a loop
// endpoint model returns credits after 0 to 7 cycles, lfsr driven
// credits are withheld for the first eight entries of the table
// msi order check assumes the vector latency of interrupt_ctrl
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_dma_tx;

    localparam int init_posted    = 4;
    localparam int init_nonposted = 2;
    localparam int num_entries    = 12;
    localparam int cycle_limit    = num_entries * 64;

    localparam logic [1:0] op_rd  = 2'd0;
    localparam logic [1:0] op_wr  = 2'd1;
    localparam logic [1:0] op_irq = 2'd2;

    typedef struct packed {
        logic [1:0]     op;
        logic [31:0]    addr;
        logic [31:0]    data;       // read length or write data
        logic [3:0]     vec_mask;   // irq lines to pulse
    } stim_t;

    logic                   trn_clk;
    logic                   reset;
    tlp_pkg::rd_req_t       rd_req;
    logic                   rd_req_valid;
    logic                   rd_req_ready;
    tlp_pkg::wr_req_t       wr_req;
    logic                   wr_req_valid;
    logic                   wr_req_ready;
    logic [3:0]             irq;
    tlp_pkg::credit_ret_t   credit_ret = '0;
    tlp_pkg::tlp_beat_t     tx_beat;

    stim_t              stim_table [num_entries];
    tlp_pkg::rd_req_t   rd_exp [$];     // expected reads in order
    tlp_pkg::wr_req_t   wr_exp [$];
    int                 p_due [$];      // credit return cycles
    int                 np_due [$];
    logic [3:0]         pend_vec = '0;
    int                 trig_cycle [4];
    int                 p_out = 0;      // outstanding posted beats
    int                 np_out = 0;
    logic [7:0]         rd_tag = 8'd0;
    logic [31:0]        lfsr = 32'he04d5311;
    int                 cycle_cnt = 0;
    logic               withhold = 1'b1;
    logic               started = 1'b0;
    int                 error_count = 0;

    initial trn_clk = 1'b0;
    always #20 trn_clk = ~trn_clk;

    dma_tx_top #(
        .init_posted_credits    (init_posted),
        .init_nonposted_credits (init_nonposted),
        .max_burst              (4),
        .num_vectors            (4)
    ) i_dut (
        .trn_clk      (trn_clk),
        .reset        (reset),
        .rd_req       (rd_req),
        .rd_req_valid (rd_req_valid),
        .rd_req_ready (rd_req_ready),
        .wr_req       (wr_req),
        .wr_req_valid (wr_req_valid),
        .wr_req_ready (wr_req_ready),
        .irq          (irq),
        .credit_ret   (credit_ret),
        .tx_beat      (tx_beat)
    );

    bind dma_tx_top dma_tx_assert i_assert (
        .trn_clk       (trn_clk),
        .reset         (reset),
        .rd_turn       (rd_turn),
        .wr_turn       (wr_turn),
        .int_turn      (int_turn),
        .rd_driven     (rd_driven),
        .wr_driven     (wr_driven),
        .int_driven    (int_driven),
        .tx_beat       (tx_beat),
        .posted_cnt    (i_tx_port.posted_cnt),
        .nonposted_cnt (i_tx_port.nonposted_cnt)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic report_failure(input string msg);
        error_count++;
        $display("FAIL %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_delay(output int d);
        d = 0;
        for (int b = 0; b < 3; b++) begin
            lfsr = lfsr_next(lfsr);
            d = (d << 1) | int'(lfsr[0]);   // one step per bit
        end
    endtask

    task automatic check_rd(input tlp_pkg::tlp_beat_t beat, input tlp_pkg::rd_req_t req,
                            input logic [7:0] tag);
        if (beat.kind !== tlp_pkg::tlp_mrd || beat.addr !== req.addr ||
            beat.len !== req.len || beat.tag !== tag)
            report_failure($sformatf("read beat addr %h len %0d tag %0d, expected %h %0d %0d",
                beat.addr, beat.len, beat.tag, req.addr, req.len, tag));
    endtask

    task automatic check_wr(input tlp_pkg::tlp_beat_t beat, input tlp_pkg::wr_req_t req);
        if (beat.kind !== tlp_pkg::tlp_mwr || beat.addr !== req.addr ||
            beat.len !== 10'd1 || beat.tag !== 8'd0 || beat.data !== req.data)
            report_failure($sformatf("write beat addr %h data %h, expected %h %h",
                beat.addr, beat.data, req.addr, req.data));
    endtask

    task automatic check_msi(input tlp_pkg::tlp_beat_t beat, input int vec);
        logic [31:0] exp_addr;
        exp_addr = tlp_pkg::msi_base_addr + 32'(vec * 4);
        if (beat.kind !== tlp_pkg::tlp_msi || beat.addr !== exp_addr ||
            beat.len !== 10'd1 || beat.data !== 32'(vec))
            report_failure($sformatf("msi addr %h data %0d, expected vector %0d at %h",
                beat.addr, beat.data, vec, exp_addr));
    endtask

    task automatic check_ready(input logic ready, input logic exp_ready, input string which);
        if (ready !== exp_ready)
            report_failure($sformatf("%s ready %b, expected %b", which, ready, exp_ready));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // monitor and endpoint credit model
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge trn_clk) begin : monitor
        int dly;
        int idx;
        int exp_v;
        credit_ret <= '0;
        if (!reset) begin
            if (tx_beat.valid) begin
                if (!started)
                    report_failure("tx beat seen before any request");
                draw_delay(dly);
                case (tx_beat.kind)
                    tlp_pkg::tlp_mrd: begin
                        if (rd_exp.size() == 0)
                            report_failure("read beat with no read request queued");
                        check_rd(tx_beat, rd_exp.pop_front(), rd_tag);
                        rd_tag = rd_tag + 8'd1;
                        np_out++;
                        np_due.push_back(cycle_cnt + dly);
                    end
                    tlp_pkg::tlp_mwr: begin
                        if (wr_exp.size() == 0)
                            report_failure("write beat with no write request queued");
                        check_wr(tx_beat, wr_exp.pop_front());
                        p_out++;
                        p_due.push_back(cycle_cnt + dly);
                    end
                    tlp_pkg::tlp_msi: begin
                        exp_v = -1;
                        // lowest vector that was surely latched at send time
                        for (int v = 3; v >= 0; v--)
                            if (pend_vec[v] && trig_cycle[v] <= cycle_cnt - 3)
                                exp_v = v;
                        if (exp_v < 0)
                            report_failure("msi beat with no interrupt pending");
                        check_msi(tx_beat, exp_v);
                        pend_vec[exp_v] = 1'b0;
                        p_out++;
                        p_due.push_back(cycle_cnt + dly);
                    end
                    default: report_failure("beat with unknown tlp kind");
                endcase
                if (p_out > init_posted || np_out > init_nonposted)
                    report_failure($sformatf("outstanding beats %0d posted %0d non-posted",
                        p_out, np_out));
            end
            if (!withhold) begin
                idx = -1;
                foreach (p_due[i]) if (idx < 0 && p_due[i] <= cycle_cnt) idx = i;
                if (idx >= 0) begin
                    p_due.delete(idx);
                    credit_ret.posted <= 1'b1;
                    p_out--;
                end
                idx = -1;
                foreach (np_due[i]) if (idx < 0 && np_due[i] <= cycle_cnt) idx = i;
                if (idx >= 0) begin
                    np_due.delete(idx);
                    credit_ret.nonposted <= 1'b1;
                    np_out--;
                end
            end
        end
    end

    // cycle counter and timeout
    always @(posedge trn_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("simulation timed out after %0d cycles, requests still outstanding",
                cycle_cnt);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial begin : stimulus
        reset        = 1'b1;
        rd_req       = '0;
        rd_req_valid = 1'b0;
        wr_req       = '0;
        wr_req_valid = 1'b0;
        irq          = '0;
        foreach (trig_cycle[v]) trig_cycle[v] = 0;

        stim_table[0]  = '{op_rd,  32'h1000_0000, 32'd16,        4'b0000};
        stim_table[1]  = '{op_wr,  32'h2000_0000, 32'hdead_beef, 4'b0000};
        stim_table[2]  = '{op_rd,  32'h1000_0040, 32'd8,         4'b0000};
        stim_table[3]  = '{op_irq, 32'h0,         32'h0,         4'b0100};
        stim_table[4]  = '{op_rd,  32'h1000_0080, 32'd1,         4'b0000};
        stim_table[5]  = '{op_wr,  32'h2000_0004, 32'h1234_5678, 4'b0000};
        stim_table[6]  = '{op_irq, 32'h0,         32'h0,         4'b1010};  // lowest first
        stim_table[7]  = '{op_wr,  32'h2000_0008, 32'ha5a5_0001, 4'b0000};
        stim_table[8]  = '{op_rd,  32'h1000_00c0, 32'd32,        4'b0000};
        stim_table[9]  = '{op_wr,  32'h2000_000c, 32'h0bad_cafe, 4'b0000};
        stim_table[10] = '{op_irq, 32'h0,         32'h0,         4'b0001};
        stim_table[11] = '{op_rd,  32'h1000_0100, 32'd4,         4'b0000};

        repeat (8) @(posedge trn_clk);
        reset <= 1'b0;
        repeat (10) @(posedge trn_clk);     // bus must stay quiet here
        started = 1'b1;

        for (int i = 0; i < num_entries; i++) begin
            if (i == 8) begin
                repeat (40) @(posedge trn_clk);     // engines starve on credit
                withhold = 1'b0;
            end
            @(posedge trn_clk);
            case (stim_table[i].op)
                op_rd: begin
                    rd_req       <= '{addr: stim_table[i].addr,
                                      len: stim_table[i].data[9:0]};
                    rd_req_valid <= 1'b1;
                    rd_exp.push_back('{addr: stim_table[i].addr,
                                       len: stim_table[i].data[9:0]});
                    do @(posedge trn_clk); while (!rd_req_ready);
                    rd_req_valid <= 1'b0;
                end
                op_wr: begin
                    wr_req       <= '{addr: stim_table[i].addr, data: stim_table[i].data};
                    wr_req_valid <= 1'b1;
                    wr_exp.push_back('{addr: stim_table[i].addr, data: stim_table[i].data});
                    do @(posedge trn_clk); while (!wr_req_ready);
                    wr_req_valid <= 1'b0;
                end
                default: begin
                    irq <= stim_table[i].vec_mask;
                    for (int v = 0; v < 4; v++) begin
                        if (stim_table[i].vec_mask[v]) begin
                            trig_cycle[v] = cycle_cnt;
                            pend_vec[v]   = 1'b1;
                        end
                    end
                    @(posedge trn_clk);
                    irq <= '0;
                end
            endcase
        end

        // drain, timeout guards this wait
        while (rd_exp.size() != 0 || wr_exp.size() != 0 || pend_vec != 4'b0000)
            @(posedge trn_clk);
        repeat (16) @(posedge trn_clk);
        // both queues are empty now
        check_ready(rd_req_ready, 1'b1, "read");
        check_ready(wr_req_ready, 1'b1, "write");

        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/dma_tx_assert.sv
////////////////////////////////////////////////////////////////////////////
// concurrent checks on the dma transmit side, bound into dma_tx_top
// credit counters are taken from the tx port instance
// all checks are disabled while reset is high
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_tx_assert (
    input  wire logic                   trn_clk,
    input  wire logic                   reset,
    input  wire logic                   rd_turn,
    input  wire logic                   wr_turn,
    input  wire logic                   int_turn,
    input  wire logic                   rd_driven,
    input  wire logic                   wr_driven,
    input  wire logic                   int_driven,
    input  wire tlp_pkg::tlp_beat_t     tx_beat,
    input  wire logic [7:0]             posted_cnt,
    input  wire logic [7:0]             nonposted_cnt
);

    logic any_turn;
    logic any_driven;

    assign any_turn   = rd_turn || wr_turn || int_turn;
    assign any_driven = rd_driven || wr_driven || int_driven;

    // one owner of the bus at a time
    a_one_driver : assert property (@(posedge trn_clk) disable iff (reset)
        $onehot0({rd_driven, wr_driven, int_driven}))
        else $error("more than one source drives the bus");

    a_posted_credit : assert property (@(posedge trn_clk) disable iff (reset)
        (tx_beat.valid && tx_beat.kind != tlp_pkg::tlp_mrd) |-> (posted_cnt != 8'd0))
        else $error("posted beat sent with no posted credit");

    a_nonposted_credit : assert property (@(posedge trn_clk) disable iff (reset)
        (tx_beat.valid && tx_beat.kind == tlp_pkg::tlp_mrd) |-> (nonposted_cnt != 8'd0))
        else $error("read beat sent with no non-posted credit");

    // turns only go out on an idle bus
    a_turn_idle : assert property (@(posedge trn_clk) disable iff (reset)
        any_turn |-> !any_driven)
        else $error("turn issued while a source drives");

endmodule

`default_nettype wire

//--- hw/dma_tx_top.sv
////////////////////////////////////////////////////////////////////////////
// dma transmit side: read engine, write engine, interrupt controller
// sharing one endpoint tx bus through the turn arbiter
// request to tlp latency varies, watch tx_beat.valid
// back-pressure is credit only, ready falls when a queue is full
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_tx_top #(
    parameter int init_posted_credits    = 4,
    parameter int init_nonposted_credits = 2,
    parameter int max_burst              = 4,
    parameter int num_vectors            = 4
) (
    input  logic                    trn_clk,
    input  logic                    reset,

    input  tlp_pkg::rd_req_t        rd_req,
    input  logic                    rd_req_valid,
    output logic                    rd_req_ready,

    input  tlp_pkg::wr_req_t        wr_req,
    input  logic                    wr_req_valid,
    output logic                    wr_req_ready,

    input  logic [num_vectors-1:0]  irq,
    input  tlp_pkg::credit_ret_t    credit_ret,

    output tlp_pkg::tlp_beat_t      tx_beat
);

    logic               rd_turn, wr_turn, int_turn;
    logic               rd_driven, wr_driven, int_driven;
    logic               int_req;
    logic               posted_avail, nonposted_avail;
    tlp_pkg::tlp_beat_t rd_beat, wr_beat, int_beat;

    endpoint_arbiter i_arbiter (
        .trn_clk    (trn_clk),
        .reset      (reset),
        .rd_driven  (rd_driven),
        .wr_driven  (wr_driven),
        .int_driven (int_driven),
        .int_req    (int_req),
        .rd_turn    (rd_turn),
        .wr_turn    (wr_turn),
        .int_turn   (int_turn)
    );

    rd_request_engine #(.max_burst(max_burst)) i_rd_engine (
        .trn_clk         (trn_clk),
        .reset           (reset),
        .rd_req          (rd_req),
        .rd_req_valid    (rd_req_valid),
        .rd_req_ready    (rd_req_ready),
        .turn            (rd_turn),
        .nonposted_avail (nonposted_avail),
        .driven          (rd_driven),
        .beat            (rd_beat)
    );

    wr_request_engine #(.max_burst(max_burst)) i_wr_engine (
        .trn_clk      (trn_clk),
        .reset        (reset),
        .wr_req       (wr_req),
        .wr_req_valid (wr_req_valid),
        .wr_req_ready (wr_req_ready),
        .turn         (wr_turn),
        .posted_avail (posted_avail),
        .driven       (wr_driven),
        .beat         (wr_beat)
    );

    interrupt_ctrl #(.num_vectors(num_vectors)) i_int_ctrl (
        .trn_clk      (trn_clk),
        .reset        (reset),
        .irq          (irq),
        .turn         (int_turn),
        .posted_avail (posted_avail),   // msi shares posted credit
        .int_req      (int_req),
        .driven       (int_driven),
        .beat         (int_beat)
    );

    endpoint_tx_port #(
        .init_posted_credits    (init_posted_credits),
        .init_nonposted_credits (init_nonposted_credits)
    ) i_tx_port (
        .trn_clk         (trn_clk),
        .reset           (reset),
        .rd_beat         (rd_beat),
        .wr_beat         (wr_beat),
        .int_beat        (int_beat),
        .credit_ret      (credit_ret),
        .tx_beat         (tx_beat),
        .posted_avail    (posted_avail),
        .nonposted_avail (nonposted_avail)
    );

endmodule

`default_nettype wire

//--- hw/endpoint_tx_port.sv
////////////////////////////////////////////////////////////////////////////
// merges source beats onto tx_beat, sources must drive zero when idle
// posted and non-posted credit counters, 8 bits, saturating
// availability accounts for a beat emitted in the same cycle
// a credit returned this cycle is only offered next cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module endpoint_tx_port #(
    parameter int init_posted_credits    = 4,
    parameter int init_nonposted_credits = 2
) (
    input  logic                    trn_clk,
    input  logic                    reset,

    input  tlp_pkg::tlp_beat_t      rd_beat,
    input  tlp_pkg::tlp_beat_t      wr_beat,
    input  tlp_pkg::tlp_beat_t      int_beat,
    input  tlp_pkg::credit_ret_t    credit_ret,

    output tlp_pkg::tlp_beat_t      tx_beat,
    output logic                    posted_avail,
    output logic                    nonposted_avail
);

    logic [7:0] posted_cnt;
    logic [7:0] nonposted_cnt;
    logic       posted_use;
    logic       nonposted_use;

    // turns are exclusive so at most one beat is nonzero
    assign tx_beat = tlp_pkg::tlp_beat_t'(rd_beat | wr_beat | int_beat);

    assign nonposted_use = tx_beat.valid && (tx_beat.kind == tlp_pkg::tlp_mrd);
    assign posted_use    = tx_beat.valid && (tx_beat.kind != tlp_pkg::tlp_mrd);

    assign posted_avail    = posted_cnt > {7'd0, posted_use};
    assign nonposted_avail = nonposted_cnt > {7'd0, nonposted_use};

    ////////////////////////////////////////////////////////////////////////////
    // credit counters
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            posted_cnt    <= 8'(init_posted_credits);
            nonposted_cnt <= 8'(init_nonposted_credits);
        end else begin
            // return and use in one cycle cancel out
            if (credit_ret.posted && !posted_use && posted_cnt != 8'hff)
                posted_cnt <= posted_cnt + 8'd1;
            else if (posted_use && !credit_ret.posted && posted_cnt != 8'h00)
                posted_cnt <= posted_cnt - 8'd1;

            if (credit_ret.nonposted && !nonposted_use && nonposted_cnt != 8'hff)
                nonposted_cnt <= nonposted_cnt + 8'd1;
            else if (nonposted_use && !credit_ret.nonposted && nonposted_cnt != 8'h00)
                nonposted_cnt <= nonposted_cnt - 8'd1;
        end
    end

endmodule

`default_nettype wire

//--- hw/interrupt_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// latches rising irq edges as pending vectors
// one msi write per turn, lowest pending vector first
// int_req stays high while any vector is pending
// msi data carries the vector number
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module interrupt_ctrl #(
    parameter int num_vectors = 4
) (
    input  logic                    trn_clk,
    input  logic                    reset,

    input  logic [num_vectors-1:0]  irq,
    input  logic                    turn,
    input  logic                    posted_avail,
    output logic                    int_req,
    output logic                    driven,
    output tlp_pkg::tlp_beat_t      beat
);

    localparam int vec_w = (num_vectors > 1) ? $clog2(num_vectors) : 1;

    logic [num_vectors-1:0] irq_q;
    logic [num_vectors-1:0] pending;
    logic [num_vectors-1:0] clr_mask;
    logic [vec_w-1:0]       low_vec;
    logic                   found;
    logic                   send;

    // priority pick, lowest index wins
    always_comb begin
        low_vec = '0;
        found   = 1'b0;
        for (int i = 0; i < num_vectors; i++) begin
            if (pending[i] && !found) begin
                low_vec = i[vec_w-1:0];
                found   = 1'b1;
            end
        end
    end

    assign send     = turn && found && posted_avail;
    assign clr_mask = send ? (num_vectors'(1) << low_vec) : '0;
    assign int_req  = |pending;
    assign driven   = beat.valid;   // one cycle per turn

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            irq_q   <= '0;
            pending <= '0;
            beat    <= '0;
        end else begin
            irq_q   <= irq;
            pending <= (pending & ~clr_mask) | (irq & ~irq_q);   // new edges win
            if (send) begin
                beat <= '{valid: 1'b1, kind: tlp_pkg::tlp_msi,
                          addr: tlp_pkg::msi_base_addr + (32'(low_vec) << 2),
                          len: 10'd1, tag: 8'h0, data: 32'(low_vec)};
            end else begin
                beat <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/wr_request_engine.sv
////////////////////////////////////////////////////////////////////////////
// memory write engine, four entry request queue
// every write is one dword, tag zero
// first beat one cycle after turn, up to max_burst beats per turn
// checks posted_avail before each beat
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module wr_request_engine #(
    parameter int max_burst = 4
) (
    input  logic                trn_clk,
    input  logic                reset,

    input  tlp_pkg::wr_req_t    wr_req,
    input  logic                wr_req_valid,
    output logic                wr_req_ready,

    input  logic                turn,
    input  logic                posted_avail,
    output logic                driven,
    output tlp_pkg::tlp_beat_t  beat
);

    tlp_pkg::wr_req_t   q_mem [4];
    logic [1:0]         wr_ptr;
    logic [1:0]         rd_ptr;
    logic [2:0]         q_count;
    logic [7:0]         burst_cnt;
    logic               push;
    logic               can_issue;
    logic               start;
    logic               cont;
    logic               pop;

    assign wr_req_ready = (q_count != 3'd4);    // low when full
    assign push         = wr_req_valid && wr_req_ready;

    assign can_issue = (q_count != 3'd0) && posted_avail;
    assign start     = turn && can_issue;
    assign cont      = beat.valid && can_issue && (burst_cnt < 8'(max_burst));
    assign pop       = start || cont;

    assign driven = beat.valid;

    ////////////////////////////////////////////////////////////////////////////
    // request queue
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (push) q_mem[wr_ptr] <= wr_req;
    end

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            wr_ptr  <= 2'd0;
            rd_ptr  <= 2'd0;
            q_count <= 3'd0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 2'd1;
            if (pop) rd_ptr <= rd_ptr + 2'd1;
            q_count <= q_count + {2'b00, push} - {2'b00, pop};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // beat formatting
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            beat      <= '0;
            burst_cnt <= 8'd0;
        end else begin
            if (pop) begin
                beat <= '{valid: 1'b1, kind: tlp_pkg::tlp_mwr,
                          addr: q_mem[rd_ptr].addr, len: 10'd1,
                          tag: 8'h0, data: q_mem[rd_ptr].data};
                burst_cnt <= start ? 8'd1 : burst_cnt + 8'd1;
            end else begin
                beat <= '0;     // zero keeps the port merge clean
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rd_request_engine.sv
////////////////////////////////////////////////////////////////////////////
// memory read engine, four entry request queue
// first beat one cycle after turn, up to max_burst beats per turn
// checks nonposted_avail before each beat, tags count up from zero
// beat is all zero while not driving
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rd_request_engine #(
    parameter int max_burst = 4
) (
    input  logic                trn_clk,
    input  logic                reset,

    input  tlp_pkg::rd_req_t    rd_req,
    input  logic                rd_req_valid,
    output logic                rd_req_ready,

    input  logic                turn,
    input  logic                nonposted_avail,
    output logic                driven,
    output tlp_pkg::tlp_beat_t  beat
);

    tlp_pkg::rd_req_t   q_mem [4];
    logic [1:0]         wr_ptr;
    logic [1:0]         rd_ptr;
    logic [2:0]         q_count;
    logic [7:0]         burst_cnt;
    logic [7:0]         tag_cnt;
    logic               push;
    logic               can_issue;
    logic               start;
    logic               cont;
    logic               pop;

    assign rd_req_ready = (q_count != 3'd4);
    assign push         = rd_req_valid && rd_req_ready;

    assign can_issue = (q_count != 3'd0) && nonposted_avail;
    assign start     = turn && can_issue;                     // turn with work
    assign cont      = beat.valid && can_issue && (burst_cnt < 8'(max_burst));
    assign pop       = start || cont;

    assign driven = beat.valid;

    ////////////////////////////////////////////////////////////////////////////
    // request queue
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (push) q_mem[wr_ptr] <= rd_req;
    end

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            wr_ptr  <= 2'd0;
            rd_ptr  <= 2'd0;
            q_count <= 3'd0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 2'd1;
            if (pop) rd_ptr <= rd_ptr + 2'd1;
            q_count <= q_count + {2'b00, push} - {2'b00, pop};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // beat formatting
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            beat      <= '0;
            burst_cnt <= 8'd0;
            tag_cnt   <= 8'd0;
        end else begin
            if (pop) begin
                beat <= '{valid: 1'b1, kind: tlp_pkg::tlp_mrd,
                          addr: q_mem[rd_ptr].addr, len: q_mem[rd_ptr].len,
                          tag: tag_cnt, data: 32'h0};
                burst_cnt <= start ? 8'd1 : burst_cnt + 8'd1;
                tag_cnt   <= tag_cnt + 8'd1;    // wraps at 256
            end else begin
                beat <= '0;     // out of work, credit or burst
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/endpoint_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// grants the endpoint tx bus in turns, read and write alternate
// an interrupt turn follows a read/write turn when int_req is high
// int_req is sampled in the cycle the read/write turn is high
// no turn is issued until every driven signal has been seen low
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module endpoint_arbiter (
    input  logic    trn_clk,
    input  logic    reset,

    input  logic    rd_driven,
    input  logic    wr_driven,
    input  logic    int_driven,
    input  logic    int_req,

    output logic    rd_turn,
    output logic    wr_turn,
    output logic    int_turn
);

    // one-hot states
    localparam logic [3:0] st_idle     = 4'b0001;
    localparam logic [3:0] st_rw_turn  = 4'b0010;
    localparam logic [3:0] st_int_wait = 4'b0100;
    localparam logic [3:0] st_int_turn = 4'b1000;

    logic [3:0] state;
    logic       turn_bit;   // 0 read next, 1 write next

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            rd_turn  <= 1'b0;
            wr_turn  <= 1'b0;
            int_turn <= 1'b0;
            turn_bit <= 1'b0;
            state    <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (!rd_driven && !wr_driven && !int_driven) begin
                        turn_bit <= ~turn_bit;
                        rd_turn  <= !turn_bit;
                        wr_turn  <= turn_bit;
                        state    <= st_rw_turn;
                    end
                end
                st_rw_turn: begin
                    rd_turn <= 1'b0;    // single cycle pulse
                    wr_turn <= 1'b0;
                    state   <= int_req ? st_int_wait : st_idle;
                end
                st_int_wait: begin
                    // let the read/write burst finish first
                    if (!rd_driven && !wr_driven) begin
                        int_turn <= 1'b1;
                        state    <= st_int_turn;
                    end
                end
                st_int_turn: begin
                    int_turn <= 1'b0;
                    state    <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/tlp_pkg.sv
////////////////////////////////////////////////////////////////////////////
// tlp types shared by the dma transmit side
// one beat carries a whole tlp, header plus at most one data dword
// msi address is msi_base_addr plus four times the vector
// credit return pulses are worth one credit each
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package tlp_pkg;

    // tlp kind codes
    typedef enum logic [1:0] {
        tlp_mrd = 2'd0,   // memory read, non-posted
        tlp_mwr = 2'd1,   // memory write, posted
        tlp_msi = 2'd2    // msi write, posted
    } tlp_kind_e;

    // one bus beat, 85 bits
    typedef struct packed {
        logic           valid;
        tlp_kind_e      kind;
        logic [31:0]    addr;
        logic [9:0]     len;    // dwords
        logic [7:0]     tag;
        logic [31:0]    data;
    } tlp_beat_t;

    typedef struct packed {
        logic [31:0]    addr;
        logic [9:0]     len;
    } rd_req_t;

    typedef struct packed {
        logic [31:0]    addr;
        logic [31:0]    data;
    } wr_req_t;

    // endpoint credit refill
    typedef struct packed {
        logic           posted;
        logic           nonposted;
    } credit_ret_t;

    localparam logic [31:0] msi_base_addr = 32'hfee0_0000;

endpackage

`default_nettype wire
